/* verilog.f */
+incdir+common
common/cache_pkg.sv
cache/cache_array.sv
cache/cache_ctrl.sv
logic/cache_top.sv
dv/mem_model.sv
dv/tb_cache.sv

/* dv/tb_cache.sv */
`timescale 1ns/100ps

module tb_cache;

    localparam logic [31:0] SEED = 32'h96e34547;
    localparam int TIMEOUT_CYCLES = 200;

    logic                   clk;
    logic                   rst;
    cache_pkg::cpu_req_t    cpu_req;
    logic                   cpu_req_valid;
    logic [31:0]            cpu_rsp_data;
    logic                   cpu_rsp_ready;
    cache_pkg::mem_req_t    mem_req;
    logic                   mem_req_valid;
    logic                   mem_req_ready;
    logic [31:0]            mem_rsp_data;
    int                     rd_count;
    int                     wr_count;
    logic [31:0]            last_wr_addr;
    logic [31:0]            last_wr_data;

    // Stimulus table, one entry per row in each queue
    string          row_name [$];
    logic           row_reset [$];
    logic           row_wr [$];
    logic [31:0]    row_addr [$];
    logic [31:0]    row_wdata [$];
    logic [31:0]    row_exp_data [$];
    int             row_exp_rd [$];
    int             row_exp_wr [$];
    logic [31:0]    row_wb_addr [$];
    logic [31:0]    row_wb_data [$];

    // Architectural memory contents as the processor sees them
    logic [31:0]    ref_mem [logic [15:0]];

    int             error_count;
    int             rows_run;
    int             rows_failed;
    logic           timed_out;

    cache_top u_cache_top
    (
        .clk            (clk),
        .rst            (rst),
        .cpu_req        (cpu_req),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_rsp_data   (cpu_rsp_data),
        .cpu_rsp_ready  (cpu_rsp_ready),
        .mem_rsp_data   (mem_rsp_data),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_req_valid  (mem_req_valid)
    );

    mem_model u_mem_model
    (
        .clk            (clk),
        .rst            (rst),
        .mem_req        (mem_req),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_data   (mem_rsp_data),
        .rd_count       (rd_count),
        .wr_count       (wr_count),
        .last_wr_addr   (last_wr_addr),
        .last_wr_data   (last_wr_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Reference memory and table
    // ------------------------------------------------------------

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] ref_word(input logic [15:0] a);
        if (ref_mem.exists(a))
        begin
            return ref_mem[a];
        end
        return lcg_step(SEED ^ {16'h0, a});
    endfunction

    task automatic add_row(input string name, input logic rst_first, input logic wr,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input int exp_rd, input int exp_wr, input logic [31:0] wb_addr);
        logic [15:0] a;
        a = addr[15:0];
        row_name.push_back(name);
        row_reset.push_back(rst_first);
        row_wr.push_back(wr);
        row_addr.push_back(addr);
        row_wdata.push_back(wdata);
        row_exp_rd.push_back(exp_rd);
        row_exp_wr.push_back(exp_wr);
        row_wb_addr.push_back(wb_addr);
        row_exp_data.push_back(ref_word(a));
        row_wb_data.push_back(ref_word(wb_addr[15:0]));
        if (wr)
        begin
            ref_mem[a] = wdata;
        end
    endtask

    // Index 3 and 7 carry the eviction cases
    task automatic load_table();
        add_row("cold_read",     0, 0, 32'h0000_0123, 32'h0,          1, 0, 32'h0);
        add_row("repeat_read",   0, 0, 32'h0000_0123, 32'h0,          0, 0, 32'h0);
        add_row("write_hit",     0, 1, 32'h0000_0123, 32'hcafe_0001,  0, 0, 32'h0);
        add_row("read_back",     0, 0, 32'h0000_0123, 32'h0,          0, 0, 32'h0);
        add_row("dirty_evict",   0, 0, 32'h0000_0453, 32'h0,          1, 1, 32'h0000_0123);
        add_row("refetch_old",   0, 0, 32'h0000_0123, 32'h0,          1, 0, 32'h0);
        add_row("write_miss",    0, 1, 32'h0000_00a7, 32'h1234_5678,  1, 0, 32'h0);
        add_row("evict_write",   0, 0, 32'h0000_00b7, 32'h0,          1, 1, 32'h0000_00a7);
        add_row("upper_bits",    0, 0, 32'hffff_0123, 32'h0,          0, 0, 32'h0);
        add_row("after_reset",   1, 0, 32'h0000_0123, 32'h0,          1, 0, 32'h0);
        add_row("reset_repeat",  0, 0, 32'h0000_0123, 32'h0,          0, 0, 32'h0);
        add_row("clean_refetch", 0, 0, 32'h0000_00b7, 32'h0,          1, 0, 32'h0);
        add_row("old_written",   0, 0, 32'h0000_00a7, 32'h0,          1, 0, 32'h0);
    endtask

    // ------------------------------------------------------------
    // Checking and row execution
    // ------------------------------------------------------------

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("FAILED %s %s: expected %h, actual %h", name, what, expected, actual);
            error_count = error_count + 1;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_row(input int i);
        int             start_rd;
        int             start_wr;
        int             errs_before;
        int             cycles;
        logic           got;
        logic [31:0]    data;
        if (row_reset[i])
        begin
            apply_reset();
        end
        errs_before = error_count;
        start_rd    = rd_count;
        start_wr    = wr_count;
        @(negedge clk);
        cpu_req.addr  = row_addr[i];
        cpu_req.wr    = row_wr[i];
        cpu_req.wdata = row_wdata[i];
        cpu_req_valid = 1'b1;
        got    = 1'b0;
        cycles = 0;
        data   = '0;
        while (!got && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cpu_rsp_ready)
            begin
                got  = 1'b1;
                data = cpu_rsp_data;
            end
        end
        if (!got)
        begin
            $display("Row %s: the cache gave no response within %0d cycles",
                     row_name[i], TIMEOUT_CYCLES);
            error_count = error_count + 1;
            rows_failed = rows_failed + 1;
            timed_out   = 1'b1;
        end
        else
        begin
            // Hold valid through the ready edge
            @(negedge clk);
            cpu_req_valid = 1'b0;
            if (!row_wr[i])
            begin
                check_value(row_name[i], "read data", row_exp_data[i], data);
            end
            check_value(row_name[i], "memory reads", row_exp_rd[i], rd_count - start_rd);
            check_value(row_name[i], "memory writes", row_exp_wr[i], wr_count - start_wr);
            if (row_exp_wr[i] > 0)
            begin
                check_value(row_name[i], "write-back address", row_wb_addr[i], last_wr_addr);
                check_value(row_name[i], "write-back data", row_wb_data[i], last_wr_data);
            end
            if (error_count == errs_before)
            begin
                $display("Row %-14s ok", row_name[i]);
            end
            else
            begin
                $display("Row %-14s failed", row_name[i]);
                rows_failed = rows_failed + 1;
            end
        end
        rows_run = rows_run + 1;
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial
    begin
        rst           = 1'b1;
        cpu_req       = '0;
        cpu_req_valid = 1'b0;
        error_count   = 0;
        rows_run      = 0;
        rows_failed   = 0;
        timed_out     = 1'b0;
        load_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < row_name.size() && !timed_out; i++)
        begin
            run_row(i);
        end
        $display("Rows run: %0d, rows failed: %0d, check errors: %0d",
                 rows_run, rows_failed, error_count);
        if (error_count == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* dv/mem_model.sv */
`timescale 1ns/100ps

module mem_model
(
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::mem_req_t     mem_req,
    input  logic                    mem_req_valid,
    output logic                    mem_req_ready,
    output logic [31:0]             mem_rsp_data,

    // Traffic log
    output int                      rd_count,
    output int                      wr_count,
    output logic [31:0]             last_wr_addr,
    output logic [31:0]             last_wr_data
);

    localparam logic [31:0] SEED = 32'h96e34547;

    logic [31:0]    mem [65536];
    logic [31:0]    rnd_state;
    int             wait_left;

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    initial
    begin
        for (int a = 0; a < 65536; a++)
        begin
            mem[a] = lcg_step(SEED ^ a);
        end
        rnd_state     = SEED;
        wait_left     = -1;
        mem_req_ready = 1'b0;
        mem_rsp_data  = '0;
        rd_count      = 0;
        wr_count      = 0;
        last_wr_addr  = '0;
        last_wr_data  = '0;
    end

    // ------------------------------------------------------------
    // Ready pulse after 0 to 3 wait cycles
    // ------------------------------------------------------------

    always @(negedge clk)
    begin
        if (rst)
        begin
            mem_req_ready = 1'b0;
            wait_left     = -1;
        end
        else if (mem_req_ready)
        begin
            mem_req_ready = 1'b0;
        end
        else if (mem_req_valid)
        begin
            if (wait_left < 0)
            begin
                // Upper bits of the LCG are the better ones
                rnd_state = lcg_step(rnd_state);
                wait_left = rnd_state[17:16];
            end
            if (wait_left == 0)
            begin
                mem_req_ready = 1'b1;
                wait_left     = -1;
                if (mem_req.wr)
                begin
                    mem[mem_req.addr[15:0]] = mem_req.wdata;
                    wr_count     = wr_count + 1;
                    last_wr_addr = mem_req.addr;
                    last_wr_data = mem_req.wdata;
                end
                else
                begin
                    mem_rsp_data = mem[mem_req.addr[15:0]];
                    rd_count     = rd_count + 1;
                end
            end
            else
            begin
                wait_left = wait_left - 1;
            end
        end
    end

endmodule

/* logic/cache_top.sv */
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_top
(
    input  logic                        clk,
    input  logic                        rst,

    // Processor port
    input  cache_pkg::cpu_req_t         cpu_req,
    input  logic                        cpu_req_valid,
    output logic [`CACHE_DATA_W-1:0]    cpu_rsp_data,
    output logic                        cpu_rsp_ready,

    // Memory port
    input  logic [`CACHE_DATA_W-1:0]    mem_rsp_data,
    input  logic                        mem_req_ready,
    output cache_pkg::mem_req_t         mem_req,
    output logic                        mem_req_valid
);

    logic [`CACHE_INDEX_W-1:0]  rd_index;
    logic [`CACHE_INDEX_W-1:0]  wr_index;
    logic                       wr_en;
    cache_pkg::cache_line_t     rd_line;
    cache_pkg::cache_line_t     wr_line;

    cache_ctrl u_cache_ctrl
    (
        .clk            (clk),
        .rst            (rst),
        .cpu_req        (cpu_req),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_rsp_data   (cpu_rsp_data),
        .cpu_rsp_ready  (cpu_rsp_ready),
        .mem_rsp_data   (mem_rsp_data),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_req_valid  (mem_req_valid),
        .rd_line        (rd_line),
        .rd_index       (rd_index),
        .wr_en          (wr_en),
        .wr_index       (wr_index),
        .wr_line        (wr_line)
    );

    cache_array u_cache_array
    (
        .clk            (clk),
        .rst            (rst),
        .rd_index       (rd_index),
        .rd_line        (rd_line),
        .wr_en          (wr_en),
        .wr_index       (wr_index),
        .wr_line        (wr_line)
    );

endmodule

/* cache/cache_ctrl.sv */
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_ctrl
(
    input  logic                        clk,
    input  logic                        rst,

    // Processor side
    input  cache_pkg::cpu_req_t         cpu_req,
    input  logic                        cpu_req_valid,
    output logic [`CACHE_DATA_W-1:0]    cpu_rsp_data,
    output logic                        cpu_rsp_ready,

    // Memory side
    input  logic [`CACHE_DATA_W-1:0]    mem_rsp_data,
    input  logic                        mem_req_ready,
    output cache_pkg::mem_req_t         mem_req,
    output logic                        mem_req_valid,

    // Line storage
    input  cache_pkg::cache_line_t      rd_line,
    output logic [`CACHE_INDEX_W-1:0]   rd_index,
    output logic                        wr_en,
    output logic [`CACHE_INDEX_W-1:0]   wr_index,
    output cache_pkg::cache_line_t      wr_line
);

    localparam int PAD_W = `CACHE_ADDR_W - `CACHE_TAG_W - `CACHE_INDEX_W;

    cache_pkg::cache_state_t    state;
    cache_pkg::cache_state_t    state_next;

    logic [`CACHE_INDEX_W-1:0]  req_index;
    logic [`CACHE_TAG_W-1:0]    req_tag;
    logic [`CACHE_ADDR_W-1:0]   fill_addr;
    logic [`CACHE_ADDR_W-1:0]   victim_addr;
    logic                       hit;
    logic                       victim_dirty;
    logic                       mem_done;

    // ------------------------------------------------------------
    // Address split and tag compare
    // ------------------------------------------------------------

    assign req_index = cpu_req.addr[`CACHE_INDEX_W-1:0];
    assign req_tag   = cpu_req.addr[`CACHE_INDEX_W +: `CACHE_TAG_W];

    assign hit          = rd_line.valid && (rd_line.tag == req_tag);
    // Stale dirty bits after reset are ignored
    assign victim_dirty = rd_line.valid && rd_line.dirty;

    // Upper address bits are dropped on the way out
    assign fill_addr   = {{PAD_W{1'b0}}, req_tag, req_index};
    assign victim_addr = {{PAD_W{1'b0}}, rd_line.tag, req_index};

    assign mem_done = mem_req_valid && mem_req_ready;

    assign rd_index = req_index;
    assign wr_index = req_index;

    // ------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= cache_pkg::IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            cache_pkg::IDLE:
            begin
                if (cpu_req_valid)
                begin
                    state_next = cache_pkg::COMPARE;
                end
            end
            cache_pkg::COMPARE:
            begin
                if (hit)
                begin
                    state_next = cache_pkg::IDLE;
                end
                else if (victim_dirty)
                begin
                    state_next = cache_pkg::WRITE_BACK;
                end
                else
                begin
                    state_next = cache_pkg::ALLOCATE;
                end
            end
            cache_pkg::WRITE_BACK:
            begin
                if (mem_done)
                begin
                    state_next = cache_pkg::ALLOCATE;
                end
            end
            cache_pkg::ALLOCATE:
            begin
                // Back to compare, which now hits
                if (mem_done)
                begin
                    state_next = cache_pkg::COMPARE;
                end
            end
            default:
            begin
                state_next = cache_pkg::IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------
    // Processor response and line updates
    // ------------------------------------------------------------

    assign cpu_rsp_ready = (state == cache_pkg::COMPARE) && hit;
    assign cpu_rsp_data  = rd_line.data;

    always_comb
    begin
        wr_en   = 1'b0;
        wr_line = rd_line;
        if ((state == cache_pkg::COMPARE) && hit && cpu_req.wr)
        begin
            wr_en         = 1'b1;
            wr_line.dirty = 1'b1;
            wr_line.data  = cpu_req.wdata;
        end
        else if ((state == cache_pkg::ALLOCATE) && mem_done)
        begin
            // Fetched word lands clean
            wr_en         = 1'b1;
            wr_line.valid = 1'b1;
            wr_line.dirty = 1'b0;
            wr_line.tag   = req_tag;
            wr_line.data  = mem_rsp_data;
        end
    end

    // ------------------------------------------------------------
    // Memory request
    // ------------------------------------------------------------

    // Valid drops after each ready, so a fill after a write-back
    // starts one cycle into ALLOCATE
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_valid <= 1'b0;
        end
        else if (mem_done)
        begin
            mem_req_valid <= 1'b0;
        end
        else if ((state == cache_pkg::COMPARE) && !hit)
        begin
            mem_req_valid <= 1'b1;
        end
        else if ((state == cache_pkg::ALLOCATE) && !mem_req_valid)
        begin
            mem_req_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == cache_pkg::COMPARE) && !hit)
        begin
            mem_req.addr  <= victim_dirty ? victim_addr : fill_addr;
            mem_req.wdata <= rd_line.data;
            mem_req.wr    <= victim_dirty;
        end
        else if ((state == cache_pkg::ALLOCATE) && !mem_req_valid)
        begin
            mem_req.addr  <= fill_addr;
            mem_req.wdata <= rd_line.data;
            mem_req.wr    <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    a_mem_req_hold: assert property (
        @(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req)
    );

    // Response only while the processor still holds its request
    a_rsp_in_compare: assert property (
        @(posedge clk) disable iff (rst)
        cpu_rsp_ready |-> (state == cache_pkg::COMPARE) && cpu_req_valid
    );

endmodule

/* cache/cache_array.sv */
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_array
(
    input  logic                        clk,
    input  logic                        rst,

    // Read port, combinational
    input  logic [`CACHE_INDEX_W-1:0]   rd_index,
    output cache_pkg::cache_line_t      rd_line,

    // Write port, one edge
    input  logic                        wr_en,
    input  logic [`CACHE_INDEX_W-1:0]   wr_index,
    input  cache_pkg::cache_line_t      wr_line
);

    logic [`CACHE_LINES-1:0]    valid_q;
    cache_pkg::cache_line_t     line_mem [`CACHE_LINES];

    // ------------------------------------------------------------
    // Valid bits
    // ------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else if (wr_en)
        begin
            valid_q[wr_index] <= wr_line.valid;
        end
    end

    // ------------------------------------------------------------
    // Tag, dirty and data storage
    // ------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            line_mem[wr_index] <= wr_line;
        end
    end

    // Stored valid field is shadowed by the reset vector
    always_comb
    begin
        rd_line       = line_mem[rd_index];
        rd_line.valid = valid_q[rd_index];
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    a_wr_index_known: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(wr_index)
    );

endmodule

/* common/cache_pkg.sv */
`include "cache_defines.svh"

package cache_pkg;

    // ------------------------------------------------------------
    // Processor and memory requests
    // ------------------------------------------------------------

    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0] addr;
        logic                     wr;
        logic [`CACHE_DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic                     wr;
    } mem_req_t;

    // ------------------------------------------------------------
    // Stored line and controller state
    // ------------------------------------------------------------

    // V + D + tag + data, 46 bits
    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [`CACHE_TAG_W-1:0]  tag;
        logic [`CACHE_DATA_W-1:0] data;
    } cache_line_t;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        COMPARE    = 2'd1,
        WRITE_BACK = 2'd2,
        ALLOCATE   = 2'd3
    } cache_state_t;

endpackage

/* common/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// ------------------------------------------------------------
// Cache geometry
// ------------------------------------------------------------

// Word width on both the processor and memory sides
`define CACHE_DATA_W    32

// Full address width, only the low bits reach the cache
`define CACHE_ADDR_W    32

// Address bits 3..0 pick the line
`define CACHE_INDEX_W   4

// Address bits 15..4 are kept as the tag
`define CACHE_TAG_W     12

// One line per index value
`define CACHE_LINES     16

`endif
